/* verilog/simd_pkg.sv */
package simd_pkg;

    // ====================
    // widths
    // ====================

    // one host instruction word
    typedef logic [31:0] insn_t;

    // core data word, one lane of stream_d
    typedef logic [15:0] word_t;

    // register number, four registers per core
    typedef logic [1:0] reg_idx_t;

    // local store address, four words per core
    typedef logic [1:0] mem_addr_t;

    // ====================
    // opcodes
    // ====================

    typedef enum logic [3:0] {
        op_nop  = 4'd0,
        op_li   = 4'd1,
        op_lid  = 4'd2,
        op_add  = 4'd3,
        op_sub  = 4'd4,
        op_mul  = 4'd5,
        op_st   = 4'd6,
        op_last = 4'd7
    } opcode_t;

    // ====================
    // instruction fields
    // ====================

    localparam int insn_op_hi      = 31;
    localparam int insn_op_lo      = 28;
    localparam int insn_rd_hi      = 27;
    localparam int insn_rd_lo      = 26;
    localparam int insn_rs_hi      = 25;
    localparam int insn_rs_lo      = 24;
    // li immediate
    localparam int insn_imm_hi     = 15;
    localparam int insn_imm_lo     = 0;
    // st address
    localparam int insn_st_hi      = 1;
    localparam int insn_st_lo      = 0;
    // last window, first and final address
    localparam int insn_win_ini_hi = 1;
    localparam int insn_win_ini_lo = 0;
    localparam int insn_win_fin_hi = 3;
    localparam int insn_win_fin_lo = 2;

endpackage

/* verilog/agu.sv */
module agu
    import simd_pkg::*;
#(
    parameter int W = $bits(mem_addr_t)
)
(
    input  logic         clk,
    input  logic         rst,
    // step enable
    input  logic         en,
    // load ini
    input  logic         start,
    input  logic [W-1:0] ini,
    input  logic [W-1:0] fin,
    output logic [W-1:0] data,
    // data sits on fin
    output logic         last
);

    // ====================
    // counter
    // ====================

    always_ff @(posedge clk) begin
        if (rst) begin
            data <= '0;
        end else if (start) begin
            data <= ini;
        end else if (en && (data != fin)) begin
            // stops on fin, never wraps
            data <= data + 1'b1;
        end
    end

    assign last = (data == fin);

endmodule

/* verilog/insn_decode.sv */
module insn_decode
    import simd_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    // host side, four-phase
    input  logic      req,
    input  insn_t     insn,
    output logic      ack,
    // result side still draining
    input  logic      stream_busy,
    // issue to the cores
    output logic      insn_v,
    output opcode_t   op,
    output reg_idx_t  rd,
    output reg_idx_t  rs,
    output word_t     imm,
    output mem_addr_t st_addr,
    // window latched from op_last
    output mem_addr_t win_ini,
    output mem_addr_t win_fin
);

    // ====================
    // handshake FSM
    // ====================

    // acked lasts one cycle, that cycle is the issue strobe
    typedef enum logic [1:0] {
        st_idle,
        st_acked,
        st_wait_low
    } state_t;

    state_t state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    // no new word while a stream is pending
                    if (req && !stream_busy) begin
                        state <= st_acked;
                    end
                end
                st_acked: begin
                    // host may already have dropped req
                    if (req) begin
                        state <= st_wait_low;
                    end else begin
                        state <= st_idle;
                    end
                end
                st_wait_low: begin
                    if (!req) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // ack high in both non-idle states
    assign ack = (state != st_idle);

    // one pulse per accepted word, same cycle as ack rising
    assign insn_v = (state == st_acked);

    // ====================
    // field capture
    // ====================

    // payload only, taken on the accepting edge
    always_ff @(posedge clk) begin
        if (state == st_idle && req && !stream_busy) begin
            op      <= opcode_t'(insn[insn_op_hi:insn_op_lo]);
            rd      <= insn[insn_rd_hi:insn_rd_lo];
            rs      <= insn[insn_rs_hi:insn_rs_lo];
            imm     <= insn[insn_imm_hi:insn_imm_lo];
            st_addr <= insn[insn_st_hi:insn_st_lo];
            // window kept until the next op_last
            if (opcode_t'(insn[insn_op_hi:insn_op_lo]) == op_last) begin
                win_ini <= insn[insn_win_ini_hi:insn_win_ini_lo];
                win_fin <= insn[insn_win_fin_hi:insn_win_fin_lo];
            end
        end
    end

endmodule

/* verilog/core_exec.sv */
module core_exec
    import simd_pkg::*;
#(
    parameter int CORENUM = 4
)
(
    input  logic                       clk,
    input  logic                       rst,
    // fixed position in the array
    input  logic [$clog2(CORENUM)-1:0] core_id,
    // broadcast instruction
    input  logic                       insn_v,
    input  opcode_t                    op,
    input  reg_idx_t                   rd,
    input  reg_idx_t                   rs,
    input  word_t                      imm,
    input  mem_addr_t                  st_addr,
    // stream read port
    input  mem_addr_t                  rd_addr,
    input  logic                       stream_v,
    output word_t                      rd_data,
    // op_last seen
    output logic                       last
);

    // ====================
    // state
    // ====================

    // four registers
    word_t regs [4];

    // four-word local store
    word_t store [4];

    // ====================
    // ALU
    // ====================

    word_t src_a;
    word_t src_b;
    word_t alu_res;

    assign src_a = regs[rd];
    assign src_b = regs[rs];

    // 16-bit context, results wrap
    always_comb begin
        case (op)
            op_add: alu_res = src_a + src_b;
            op_sub: alu_res = src_a - src_b;
            // low half of the product only
            op_mul: alu_res = src_a * src_b;
            default: alu_res = src_a;
        endcase
    end

    // ====================
    // execute
    // ====================

    always_ff @(posedge clk) begin
        if (insn_v) begin
            case (op)
                op_li: begin
                    regs[rd] <= imm;
                end
                op_lid: begin
                    // zero-extended core index
                    regs[rd] <= word_t'(core_id);
                end
                op_add, op_sub, op_mul: begin
                    regs[rd] <= alu_res;
                end
                op_st: begin
                    store[st_addr] <= src_b;
                end
                default: begin
                end
            endcase
        end
    end

    // read port, moves only while the window advances
    always_ff @(posedge clk) begin
        if (stream_v) begin
            rd_data <= store[rd_addr];
        end
    end

    // one-cycle flag, the cycle after op_last
    always_ff @(posedge clk) begin
        if (rst) begin
            last <= 1'b0;
        end else begin
            last <= insn_v && (op == op_last);
        end
    end

endmodule

/* verilog/stream_ctrl.sv */
module stream_ctrl
    import simd_pkg::*;
#(
    parameter int CORENUM = 4
)
(
    input  logic               clk,
    input  logic               rst,
    // one flag per core
    input  logic [CORENUM-1:0] last,
    input  logic               dst_ready,
    // window from decode
    input  mem_addr_t          win_ini,
    input  mem_addr_t          win_fin,
    output logic               dst_valid,
    output logic               dst_last,
    // read enable for agu and core ports
    output logic               stream_v,
    output logic               stream_busy,
    output mem_addr_t          rd_addr
);

    // flow
    // last -> last_n -> last_nn -> start (with dst_ready)
    // start -> stream_active -> dst_valid / dst_last
    // pending holds last_nn through low dst_ready

    logic last_any;
    logic last_n;
    logic last_nn;
    logic pending;
    logic start;
    logic stream_active;
    logic agu_last;

    // ====================
    // last detect
    // ====================

    // any core flags op_last
    assign last_any = |last;

    // two cycles of slack after op_last
    always_ff @(posedge clk) begin
        if (rst) begin
            last_n  <= 1'b0;
            last_nn <= 1'b0;
        end else begin
            last_n  <= last_any;
            last_nn <= last_n;
        end
    end

    // remember the request while the sink is stalled
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (start) begin
            pending <= 1'b0;
        end else if (last_nn) begin
            pending <= 1'b1;
        end
    end

    // loads agu with win_ini
    assign start = (last_nn || pending) && dst_ready;

    // ====================
    // window sequencing
    // ====================

    // up from start until the final address is read
    always_ff @(posedge clk) begin
        if (rst) begin
            stream_active <= 1'b0;
        end else if (start) begin
            stream_active <= 1'b1;
        end else if (stream_v && agu_last) begin
            stream_active <= 1'b0;
        end
    end

    // one address read per accepted cycle
    assign stream_v = stream_active && dst_ready;

    agu #(
        .W($bits(mem_addr_t))
    ) agu_win (
        .clk   (clk),
        .rst   (rst),
        .en    (stream_v),
        .start (start),
        .ini   (win_ini),
        .fin   (win_fin),
        .data  (rd_addr),
        .last  (agu_last)
    );

    // ====================
    // output flags
    // ====================

    // registered beside the core read ports, so stream_d lines up
    always_ff @(posedge clk) begin
        if (rst) begin
            dst_valid <= 1'b0;
            dst_last  <= 1'b0;
        end else if (dst_ready) begin
            dst_valid <= stream_active;
            dst_last  <= stream_active && agu_last;
        end
    end

    // from first flag until the final beat leaves
    assign stream_busy = last_any || last_n || last_nn || pending
                         || stream_active || dst_valid;

endmodule

/* verilog/simd_stream_top.sv */
module simd_stream_top
    import simd_pkg::*;
#(
    parameter int CORENUM = 4
)
(
    input  logic                               clk,
    input  logic                               rst,
    // host
    input  logic                               req,
    input  insn_t                              insn,
    output logic                               ack,
    // result stream
    input  logic                               dst_ready,
    output logic                               dst_valid,
    output logic                               dst_last,
    output logic [CORENUM*$bits(word_t)-1:0]   stream_d
);

    localparam int idx_w = $clog2(CORENUM);

    // ====================
    // decode
    // ====================

    logic      insn_v;
    opcode_t   op;
    reg_idx_t  rd;
    reg_idx_t  rs;
    word_t     imm;
    mem_addr_t st_addr;
    mem_addr_t win_ini;
    mem_addr_t win_fin;
    logic      stream_busy;

    insn_decode dec0 (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .insn        (insn),
        .ack         (ack),
        .stream_busy (stream_busy),
        .insn_v      (insn_v),
        .op          (op),
        .rd          (rd),
        .rs          (rs),
        .imm         (imm),
        .st_addr     (st_addr),
        .win_ini     (win_ini),
        .win_fin     (win_fin)
    );

    // ====================
    // core array
    // ====================

    logic [CORENUM-1:0] last;
    logic               stream_v;
    mem_addr_t          rd_addr;

    // core 0 in the low lane
    for (genvar g = 0; g < CORENUM; g++) begin : g_core
        localparam logic [idx_w-1:0] core_idx = g;

        core_exec #(
            .CORENUM(CORENUM)
        ) core (
            .clk      (clk),
            .rst      (rst),
            .core_id  (core_idx),
            .insn_v   (insn_v),
            .op       (op),
            .rd       (rd),
            .rs       (rs),
            .imm      (imm),
            .st_addr  (st_addr),
            .rd_addr  (rd_addr),
            .stream_v (stream_v),
            .rd_data  (stream_d[g*$bits(word_t) +: $bits(word_t)]),
            .last     (last[g])
        );
    end

    // ====================
    // result side
    // ====================

    stream_ctrl #(
        .CORENUM(CORENUM)
    ) sctl0 (
        .clk         (clk),
        .rst         (rst),
        .last        (last),
        .dst_ready   (dst_ready),
        .win_ini     (win_ini),
        .win_fin     (win_fin),
        .dst_valid   (dst_valid),
        .dst_last    (dst_last),
        .stream_v    (stream_v),
        .stream_busy (stream_busy),
        .rd_addr     (rd_addr)
    );

endmodule

/* bench/simd_stream_assertions.sv */
module simd_stream_assertions #(
    parameter int DW = 64
)
(
    input logic          clk,
    input logic          rst,
    // decode handshake
    input logic          req,
    input logic          ack,
    input logic          insn_v,
    input logic          stream_busy,
    // stream_ctrl output side
    input logic          dst_valid,
    input logic          dst_ready,
    input logic          dst_last,
    input logic [DW-1:0] stream_d
);

    // failure count, read by the testbench summary
    int fails = 0;

    // ====================
    // handshake
    // ====================

    // ack only in answer to a held req
    ack_rise: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> $past(req))
        else begin
            $error("ack rose while req was low");
            fails++;
        end

    // ack drops only once req is gone
    ack_fall: assert property (@(posedge clk) disable iff (rst) $fell(ack) |-> !$past(req))
        else begin
            $error("ack fell while req was still high");
            fails++;
        end

    // no word taken while a stream drains
    no_accept_busy: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> !$past(stream_busy))
        else begin
            $error("instruction accepted while the stream was busy");
            fails++;
        end

    // issue strobe exactly in the cycle ack rises
    issue_strobe: assert property (@(posedge clk) disable iff (rst) insn_v == $rose(ack))
        else begin
            $error("insn_v not a single pulse with ack rising");
            fails++;
        end

    // ====================
    // stream
    // ====================

    // stalled beat holds valid, last and data
    hold_stall: assert property (@(posedge clk) disable iff (rst)
        dst_valid && !dst_ready |=> dst_valid && $stable(dst_last) && $stable(stream_d))
        else begin
            $error("stalled beat changed while dst_ready was low");
            fails++;
        end

    // nothing follows the closing beat
    last_ends: assert property (@(posedge clk) disable iff (rst)
        dst_valid && dst_ready && dst_last |=> !dst_valid)
        else begin
            $error("dst_valid stayed high after the final beat");
            fails++;
        end

endmodule

// attached at the top, where decode and stream_ctrl signals meet
bind simd_stream_top simd_stream_assertions #(
    .DW($bits(stream_d))
) chk0 (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .ack         (ack),
    .insn_v      (insn_v),
    .stream_busy (stream_busy),
    .dst_valid   (dst_valid),
    .dst_ready   (dst_ready),
    .dst_last    (dst_last),
    .stream_d    (stream_d)
);

/* bench/simd_stream_tb.sv */
module simd_stream_tb
    import simd_pkg::*;
();

    localparam int CORENUM = 4;
    localparam int DW = CORENUM * $bits(word_t);

    logic          clk = 1'b0;
    logic          rst;
    logic          req;
    insn_t         insn;
    logic          ack;
    logic          dst_ready;
    logic          dst_valid;
    logic          dst_last;
    logic [DW-1:0] stream_d;

    simd_stream_top #(
        .CORENUM(CORENUM)
    ) dut0 (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .insn      (insn),
        .ack       (ack),
        .dst_ready (dst_ready),
        .dst_valid (dst_valid),
        .dst_last  (dst_last),
        .stream_d  (stream_d)
    );

    always #20 clk = ~clk;

    // ====================
    // trace contents
    // ====================

    // instructions in host order, with beats expected before each one
    insn_t         insn_q[$];
    string         insn_test_q[$];
    int            insn_prior_q[$];
    // expected beats in stream order
    logic [DW-1:0] exp_d_q[$];
    logic          exp_last_q[$];
    string         exp_test_q[$];

    int trace_lines = 0;
    int exp_total = 0;
    int beats_seen = 0;
    int errors = 0;
    logic [31:0] lfsr = 32'hb93d33b2;

    task automatic load_trace();
        int fd;
        int n;
        string line;
        string test;
        logic [31:0] word;
        logic [DW-1:0] beat;
        int lst;
        test = "none";
        fd = $fopen("bench/simd_stream_trace.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                // blank and comment lines fall through
                if (n > 0 && line.getc(0) == "T") begin
                    n = $sscanf(line, "T %s", test);
                    trace_lines++;
                end else if (n > 0 && line.getc(0) == "I") begin
                    n = $sscanf(line, "I %h", word);
                    insn_q.push_back(word);
                    insn_test_q.push_back(test);
                    insn_prior_q.push_back(exp_d_q.size());
                    trace_lines++;
                end else if (n > 0 && line.getc(0) == "B") begin
                    n = $sscanf(line, "B %h %d", beat, lst);
                    exp_d_q.push_back(beat);
                    exp_last_q.push_back(lst != 0);
                    exp_test_q.push_back(test);
                    trace_lines++;
                end
            end
            $fclose(fd);
        end
        exp_total = exp_d_q.size();
    endtask

    // ====================
    // host side
    // ====================

    // four-phase word transfer, ack sampled on the falling edge
    task automatic send_insn(input insn_t word, input string test, input int prior);
        @(posedge clk);
        insn <= word;
        req  <= 1'b1;
        @(negedge clk);
        while (!ack) begin
            @(negedge clk);
        end
        // every earlier beat must be out before the word is taken
        assert (beats_seen == prior)
        else begin
            $display("error %s: word %h accepted, expected %0d earlier beats, actual %0d",
                     test, word, prior, beats_seen);
            errors++;
        end
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        while (ack) begin
            @(negedge clk);
        end
    endtask

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h80200003;
        end
        return n;
    endfunction

    // one fresh bit per cycle for the sink
    always @(posedge clk) begin
        lfsr = lfsr_step(lfsr);
        dst_ready <= lfsr[0];
    end

    // ====================
    // beat checker
    // ====================

    // valid and ready are settled at the falling edge, transfer follows
    always @(negedge clk) begin
        if (!rst && dst_valid && dst_ready) begin
            assert (exp_d_q.size() > 0)
            else begin
                $display("beat %h arrived with no beat left in the trace", stream_d);
                errors++;
            end
            if (exp_d_q.size() > 0) begin
                assert (stream_d === exp_d_q[0] && dst_last === exp_last_q[0])
                else begin
                    $display("error %s: expected %h last %b, actual %h last %b",
                             exp_test_q[0], exp_d_q[0], exp_last_q[0], stream_d, dst_last);
                    errors++;
                end
                void'(exp_d_q.pop_front());
                void'(exp_last_q.pop_front());
                void'(exp_test_q.pop_front());
            end
            beats_seen++;
        end
    end

    // ====================
    // watchdog
    // ====================

    initial begin
        wait (trace_lines > 0);
        repeat (200 * trace_lines) @(posedge clk);
        $display("timeout: %0d of %0d beats received", beats_seen, exp_total);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // ====================
    // main sequence
    // ====================

    initial begin
        rst       = 1'b1;
        req       = 1'b0;
        insn      = '0;
        dst_ready = 1'b0;
        load_trace();
        if (trace_lines == 0) begin
            $display("trace file bench/simd_stream_trace.txt missing or empty");
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            repeat (5) @(posedge clk);
            rst <= 1'b0;
            // quiet outputs until the first request
            repeat (3) begin
                @(negedge clk);
                assert (!ack && !dst_valid && !dst_last)
                else begin
                    $display("error reset: expected ack/valid/last 000, actual %b%b%b",
                             ack, dst_valid, dst_last);
                    errors++;
                end
            end
            foreach (insn_q[i]) begin
                send_insn(insn_q[i], insn_test_q[i], insn_prior_q[i]);
            end
            wait (beats_seen >= exp_total);
            // room for any stray extra beat
            repeat (20) @(posedge clk);
            $display("summary: %0d check errors, %0d assertion failures, %0d of %0d beats",
                     errors, dut0.chk0.fails, beats_seen, exp_total);
            if (errors == 0 && dut0.chk0.fails == 0 && beats_seen == exp_total) begin
                $display("*** TEST PASSED ***");
            end else begin
                $display("*** TEST FAILED ***");
            end
            $finish;
        end
    end

endmodule

/* simd_stream.f */
verilog/simd_pkg.sv
verilog/agu.sv
verilog/insn_decode.sv
verilog/core_exec.sv
verilog/stream_ctrl.sv
verilog/simd_stream_top.sv
bench/simd_stream_assertions.sv
bench/simd_stream_tb.sv

/* bench/simd_stream_trace.txt */
# T <test name> | I <instruction hex> | B <stream_d hex, core 0 in low 16 bits> <dst_last>
# fields: op 31:28, rd 27:26, rs 25:24, imm 15:0, st addr 1:0, last ini 1:0 fin 3:2
T arith
I 10001234  li r0, 0x1234
I 1400F00D  li r1, 0xf00d
I 18000003  li r2, 3
I 1C008001  li r3, 0x8001
I 31000000  add r0, r1
I 60000000  st r0 -> 0
I 46000000  sub r1, r2
I 61000001  st r1 -> 1
I 59000000  mul r2, r1
I 62000002  st r2 -> 2
I 4C000000  sub r3, r0
I 63000003  st r3 -> 3
I 7000000C  last 0..3
B 0241024102410241 0
B F00AF00AF00AF00A 0
B D01ED01ED01ED01E 0
B 7DC07DC07DC07DC0 1
T lanes
I 20000000  lid r0, sent while arith streams
I 14000100  li r1, 0x0100
I 54000000  mul r1, r0
I 18000007  li r2, 7
I 39000000  add r2, r1
I 62000000  st r2 -> 0
I 1C00FFFF  li r3, 0xffff
I 4C000000  sub r3, r0
I 63000001  st r3 -> 1
I 70000004  last 0..1
B 0307020701070007 0
B FFFCFFFDFFFEFFFF 1
T window
I 1000A5A5  li r0, 0xa5a5
I 60000002  st r0 -> 2
I 70000009  last 1..2
B FFFCFFFDFFFEFFFF 0
B A5A5A5A5A5A5A5A5 1
T tail
I 24000000  lid r1
I 61000003  st r1 -> 3
I 7000000F  last 3..3
B 0003000200010000 1
